/* Bender.yml */
package:
  name: pkt_cap

sources:
  - files:
      - rtl/pkt_cap_pkg.sv
      - rtl/pkt_cap_ctrl_if.sv
      - rtl/pkt_cap_writer.sv
      - rtl/pkt_cap_mem.sv
      - rtl/pkt_cap_regs.sv
      - rtl/pkt_cap_top.sv
  - target: test
    files:
      - tests/pkt_cap_tb.sv

/* filelist.f */
rtl/pkt_cap_pkg.sv
rtl/pkt_cap_ctrl_if.sv
rtl/pkt_cap_writer.sv
rtl/pkt_cap_mem.sv
rtl/pkt_cap_regs.sv
rtl/pkt_cap_top.sv
tests/pkt_cap_tb.sv

/* rtl/pkt_cap_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface pkt_cap_ctrl_if
    import pkt_cap_pkg::*;
();

    // Control from the register block
    logic        en;
    logic        arm;

    // Capture results from the writer
    logic        done;
    logic        overflow;
    logic [15:0] byte_len;
    meta_u       meta;

    modport regs_mp (
        output en,
        output arm,
        input  done,
        input  overflow,
        input  byte_len,
        input  meta
    );

    modport writer_mp (
        input  en,
        input  arm,
        output done,
        output overflow,
        output byte_len,
        output meta
    );

endinterface

`default_nettype wire

/* rtl/pkt_cap_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_cap_mem
    import pkt_cap_pkg::*;
#(
    parameter int PACKET_MEM_SIZE = 256,
    localparam int MEM_DEPTH = PACKET_MEM_SIZE / DATA_BYTE_WID,
    localparam int MEM_ADDR_WID = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  wire logic                     clk,
    input  wire logic                     wr_en,
    input  wire logic [MEM_ADDR_WID-1:0]  wr_addr,
    input  wire logic [DATA_WID-1:0]      wr_data,
    input  wire logic [DATA_BYTE_WID-1:0] wr_be,
    input  wire logic                     rd_en,
    input  wire logic [MEM_ADDR_WID-1:0]  rd_addr,
    output logic [DATA_WID-1:0]           rd_data
);

    logic [DATA_BYTE_WID-1:0][7:0] mem [MEM_DEPTH];

    // Byte lanes written only where tkeep was set
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int i = 0; i < DATA_BYTE_WID; i++)
            begin
                if (wr_be[i])
                begin
                    mem[wr_addr][i] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/pkt_cap_pkg.sv */
`default_nettype none

package pkt_cap_pkg;

    // ==========================================================
    // Data and metadata widths
    // ==========================================================
    localparam int DATA_BYTE_WID = 4;
    localparam int DATA_WID = DATA_BYTE_WID * 8;

    typedef logic [7:0] tid_t;
    typedef logic [3:0] tdest_t;
    typedef logic [19:0] tuser_t;

    // Field order matches the raw word, tid in the top byte
    typedef struct packed {
        tid_t   tid;
        tdest_t tdest;
        tuser_t tuser;
    } meta_t;

    typedef union packed {
        meta_t       fields;
        logic [31:0] raw;
    } meta_u;

    localparam int META_WID = $bits(meta_t);

    // ==========================================================
    // Register map, word addresses
    // ==========================================================
    localparam int REG_ADDR_WID = 10;

    localparam logic [REG_ADDR_WID-1:0] REG_MEM_SIZE  = 10'd0;
    localparam logic [REG_ADDR_WID-1:0] REG_META_WID  = 10'd1;
    localparam logic [REG_ADDR_WID-1:0] REG_CONTROL   = 10'd2;
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS    = 10'd3;
    localparam logic [REG_ADDR_WID-1:0] REG_LENGTH    = 10'd4;
    localparam logic [REG_ADDR_WID-1:0] REG_META      = 10'd5;
    localparam logic [REG_ADDR_WID-1:0] REG_DATA_BASE = 10'd256;

endpackage

`default_nettype wire

/* rtl/pkt_cap_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_cap_regs
    import pkt_cap_pkg::*;
#(
    parameter int PACKET_MEM_SIZE = 256,
    localparam int MEM_DEPTH = PACKET_MEM_SIZE / DATA_BYTE_WID,
    localparam int MEM_ADDR_WID = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    reg_wr,
    input  wire logic                    reg_rd,
    input  wire logic [REG_ADDR_WID-1:0] reg_addr,
    input  wire logic [DATA_WID-1:0]     reg_wdata,
    output logic [DATA_WID-1:0]          reg_rdata,
    output logic                         reg_rvalid,
    pkt_cap_ctrl_if.regs_mp              ctrl,
    output logic                         rd_en,
    output logic [MEM_ADDR_WID-1:0]      rd_addr,
    input  wire logic [DATA_WID-1:0]     rd_data
);

    logic [REG_ADDR_WID-1:0] data_idx;
    logic                    data_hit;
    logic [DATA_WID-1:0]     reg_data;
    logic [DATA_WID-1:0]     reg_data_q;
    logic                    mem_sel_q;

    // ==========================================================
    // Control register
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ctrl.en  <= 1'b0;
            ctrl.arm <= 1'b0;
        end
        else
        begin
            // Arm is self clearing
            ctrl.arm <= 1'b0;
            if (reg_wr && (reg_addr == REG_CONTROL))
            begin
                ctrl.en  <= reg_wdata[0];
                ctrl.arm <= reg_wdata[1];
            end
        end
    end

    // ==========================================================
    // Read path
    // ==========================================================
    // Data window maps onto memory words
    assign data_idx = reg_addr - REG_DATA_BASE;
    assign data_hit = (reg_addr >= REG_DATA_BASE) &&
                      (data_idx < REG_ADDR_WID'(MEM_DEPTH));

    assign rd_en   = reg_rd && data_hit;
    assign rd_addr = data_idx[MEM_ADDR_WID-1:0];

    always_comb
    begin
        case (reg_addr)
            REG_MEM_SIZE: reg_data = DATA_WID'(PACKET_MEM_SIZE);
            REG_META_WID: reg_data = DATA_WID'(META_WID);
            REG_CONTROL:  reg_data = {{(DATA_WID-1){1'b0}}, ctrl.en};
            REG_STATUS:   reg_data = {{(DATA_WID-2){1'b0}}, ctrl.overflow, ctrl.done};
            REG_LENGTH:   reg_data = {{(DATA_WID-16){1'b0}}, ctrl.byte_len};
            REG_META:     reg_data = ctrl.meta.raw;
            default:      reg_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            reg_rvalid <= 1'b0;
            mem_sel_q  <= 1'b0;
        end
        else
        begin
            reg_rvalid <= reg_rd;
            if (reg_rd)
            begin
                mem_sel_q <= data_hit;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reg_rd)
        begin
            reg_data_q <= reg_data;
        end
    end

    // Memory data lands in the same cycle as the register value would
    assign reg_rdata = mem_sel_q ? rd_data : reg_data_q;

endmodule

`default_nettype wire

/* rtl/pkt_cap_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_cap_top
    import pkt_cap_pkg::*;
#(
    parameter int PACKET_MEM_SIZE = 256
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    // AXI4-Stream sink
    input  wire logic                     tvalid,
    output logic                          tready,
    input  wire logic [DATA_WID-1:0]      tdata,
    input  wire logic [DATA_BYTE_WID-1:0] tkeep,
    input  wire logic                     tlast,
    input  wire tid_t                     tid,
    input  wire tdest_t                   tdest,
    input  wire tuser_t                   tuser,
    // Register port
    input  wire logic                     reg_wr,
    input  wire logic                     reg_rd,
    input  wire logic [REG_ADDR_WID-1:0]  reg_addr,
    input  wire logic [DATA_WID-1:0]      reg_wdata,
    output logic [DATA_WID-1:0]           reg_rdata,
    output logic                          reg_rvalid
);

    localparam int MEM_DEPTH = PACKET_MEM_SIZE / DATA_BYTE_WID;
    localparam int MEM_ADDR_WID = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic                     wr_en;
    logic [MEM_ADDR_WID-1:0]  wr_addr;
    logic [DATA_WID-1:0]      wr_data;
    logic [DATA_BYTE_WID-1:0] wr_be;
    logic                     rd_en;
    logic [MEM_ADDR_WID-1:0]  rd_addr;
    logic [DATA_WID-1:0]      rd_data;

    pkt_cap_ctrl_if ctrl_if ();

    pkt_cap_writer #(
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) i_writer (
        .clk     (clk),
        .arst_n  (arst_n),
        .ctrl    (ctrl_if.writer_mp),
        .tvalid  (tvalid),
        .tready  (tready),
        .tdata   (tdata),
        .tkeep   (tkeep),
        .tlast   (tlast),
        .tid     (tid),
        .tdest   (tdest),
        .tuser   (tuser),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_be   (wr_be)
    );

    pkt_cap_mem #(
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) i_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_be   (wr_be),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    pkt_cap_regs #(
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) i_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .ctrl       (ctrl_if.regs_mp),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/pkt_cap_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_cap_writer
    import pkt_cap_pkg::*;
#(
    parameter int PACKET_MEM_SIZE = 256,
    localparam int MEM_DEPTH = PACKET_MEM_SIZE / DATA_BYTE_WID,
    localparam int MEM_ADDR_WID = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    pkt_cap_ctrl_if.writer_mp             ctrl,
    input  wire logic                     tvalid,
    output logic                          tready,
    input  wire logic [DATA_WID-1:0]      tdata,
    input  wire logic [DATA_BYTE_WID-1:0] tkeep,
    input  wire logic                     tlast,
    input  wire tid_t                     tid,
    input  wire tdest_t                   tdest,
    input  wire tuser_t                   tuser,
    output logic                          wr_en,
    output logic [MEM_ADDR_WID-1:0]       wr_addr,
    output logic [DATA_WID-1:0]           wr_data,
    output logic [DATA_BYTE_WID-1:0]      wr_be
);

    localparam int KEEP_CNT_WID = $clog2(DATA_BYTE_WID + 1);

    logic                    beat;
    logic                    pkt_start;
    logic                    armed;
    logic                    capturing;
    logic                    start_capture;
    logic                    capture_beat;
    logic                    in_range;
    logic [15:0]             beat_cnt;
    logic [KEEP_CNT_WID-1:0] keep_cnt;

    // ==========================================================
    // Stream handshake and beat qualification
    // ==========================================================
    assign tready = ctrl.en;
    assign beat   = tvalid && tready;

    // An arm pulse this cycle takes priority over any beat
    assign start_capture = beat && pkt_start && armed && !ctrl.arm;
    assign capture_beat  = start_capture || (beat && capturing && !ctrl.arm);
    assign in_range      = beat_cnt < 16'(MEM_DEPTH);

    // Bytes carried by this beat
    always_comb
    begin
        keep_cnt = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++)
        begin
            keep_cnt = keep_cnt + KEEP_CNT_WID'(tkeep[i]);
        end
    end

    // Memory write port, word index equals beat index
    assign wr_en   = capture_beat && in_range;
    assign wr_addr = beat_cnt[MEM_ADDR_WID-1:0];
    assign wr_data = tdata;
    assign wr_be   = tkeep;

    // ==========================================================
    // Capture state
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pkt_start     <= 1'b1;
            armed         <= 1'b0;
            capturing     <= 1'b0;
            beat_cnt      <= '0;
            ctrl.done     <= 1'b0;
            ctrl.overflow <= 1'b0;
            ctrl.byte_len <= '0;
        end
        else
        begin
            // Next beat starts a packet once tlast has passed
            if (beat)
            begin
                pkt_start <= tlast;
            end

            if (ctrl.arm)
            begin
                armed         <= 1'b1;
                capturing     <= 1'b0;
                beat_cnt      <= '0;
                ctrl.done     <= 1'b0;
                ctrl.overflow <= 1'b0;
                ctrl.byte_len <= '0;
            end
            else if (capture_beat)
            begin
                beat_cnt      <= beat_cnt + 16'd1;
                ctrl.byte_len <= ctrl.byte_len + 16'(keep_cnt);
                if (!in_range)
                begin
                    ctrl.overflow <= 1'b1;
                end
                if (tlast)
                begin
                    ctrl.done <= 1'b1;
                    armed     <= 1'b0;
                    capturing <= 1'b0;
                end
                else
                begin
                    capturing <= 1'b1;
                end
            end
        end
    end

    // Metadata comes from the first captured beat
    always_ff @(posedge clk)
    begin
        if (start_capture)
        begin
            ctrl.meta.fields.tid   <= tid;
            ctrl.meta.fields.tdest <= tdest;
            ctrl.meta.fields.tuser <= tuser;
        end
    end

endmodule

`default_nettype wire

/* tests/pkt_cap_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_cap_tb
    import pkt_cap_pkg::*;
();

    localparam int MEM_SIZE = 64;
    localparam int DEPTH    = MEM_SIZE / DATA_BYTE_WID;
    localparam int TIMEOUT  = 200;
    localparam int N_ROWS   = 8;

    localparam logic [1:0] ARM_NONE      = 2'd0;
    localparam logic [1:0] ARM_BEFORE    = 2'd1;
    localparam logic [1:0] ARM_IN_FLIGHT = 2'd2;

    typedef struct packed {
        logic [15:0] len;
        logic [31:0] meta;
        logic [1:0]  arm_mode;
        logic        en;
        logic [7:0]  idle;
    } row_t;

    logic                     clk;
    logic                     arst_n;
    logic                     tvalid;
    logic                     tready;
    logic [DATA_WID-1:0]      tdata;
    logic [DATA_BYTE_WID-1:0] tkeep;
    logic                     tlast;
    tid_t                     tid;
    tdest_t                   tdest;
    tuser_t                   tuser;
    logic                     reg_wr;
    logic                     reg_rd;
    logic [REG_ADDR_WID-1:0]  reg_addr;
    logic [DATA_WID-1:0]      reg_wdata;
    logic [DATA_WID-1:0]      reg_rdata;
    logic                     reg_rvalid;

    // Reference model of the capture state
    row_t        rows [N_ROWS];
    logic [31:0] ref_mem [DEPTH];
    logic [7:0]  payload [128];
    logic        armed_m;
    logic        exp_done;
    logic        exp_ovf;
    logic [15:0] exp_len;
    logic [31:0] exp_meta;
    integer      seed = 95;

    pkt_cap_top #(
        .PACKET_MEM_SIZE (MEM_SIZE)
    ) uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .tvalid     (tvalid),
        .tready     (tready),
        .tdata      (tdata),
        .tkeep      (tkeep),
        .tlast      (tlast),
        .tid        (tid),
        .tdest      (tdest),
        .tuser      (tuser),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==========================================================
    // Checking and failure
    // ==========================================================
    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    // ==========================================================
    // Register port
    // ==========================================================
    task automatic reg_write(input logic [REG_ADDR_WID-1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_WID-1:0] addr, output logic [31:0] data);
        int cnt;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        cnt = 0;
        while (!reg_rvalid)
        begin
            if (cnt == TIMEOUT)
            begin
                $display("Timed out waiting for read data from address %0d", addr);
                fail_run();
            end
            @(negedge clk);
            cnt++;
        end
        data = reg_rdata;
        // Valid is a single pulse one cycle after the strobe
        check_value($sformatf("read latency at address %0d", addr), cnt, 0);
        @(negedge clk);
        check_value($sformatf("read valid after address %0d", addr), {31'b0, reg_rvalid}, 0);
    endtask

    // ==========================================================
    // Stream driver
    // ==========================================================
    // Lanes past the packet end carry junk that must not be stored
    task automatic set_beat(input int b, input row_t row);
        tvalid = 1'b1;
        tlast  = (4 * (b + 1) >= row.len);
        for (int i = 0; i < DATA_BYTE_WID; i++)
        begin
            if (4 * b + i < row.len)
            begin
                tkeep[i]         = 1'b1;
                tdata[i*8 +: 8] = payload[4 * b + i];
            end
            else
            begin
                tkeep[i]         = 1'b0;
                tdata[i*8 +: 8] = 8'($random(seed));
            end
        end
        {tid, tdest, tuser} = row.meta;
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!tready)
        begin
            if (cnt == TIMEOUT)
            begin
                $display("Timed out waiting for tready");
                fail_run();
            end
            @(negedge clk);
            cnt++;
        end
    endtask

    task automatic send_packet(input row_t row);
        int nbeats;
        nbeats = (row.len + 3) / 4;
        for (int b = 0; b < nbeats; b++)
        begin
            // Arm lands while this packet is already in flight
            if (row.arm_mode == ARM_IN_FLIGHT && b == 2)
            begin
                tvalid = 1'b0;
                reg_write(REG_CONTROL, 32'h3);
            end
            set_beat(b, row);
            wait_ready();
            @(negedge clk);
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
    endtask

    // ==========================================================
    // Expected results
    // ==========================================================
    task automatic update_model(input row_t row);
        int   nbeats;
        logic captured;
        nbeats   = (row.len + 3) / 4;
        captured = (row.arm_mode == ARM_BEFORE) || (row.arm_mode == ARM_NONE && armed_m);
        if (row.arm_mode != ARM_NONE)
        begin
            armed_m  = 1'b1;
            exp_done = 1'b0;
            exp_ovf  = 1'b0;
            exp_len  = '0;
        end
        if (captured)
        begin
            for (int b = 0; b < nbeats; b++)
            begin
                if (b < DEPTH)
                begin
                    for (int i = 0; i < DATA_BYTE_WID; i++)
                    begin
                        if (4 * b + i < row.len)
                            ref_mem[b][i*8 +: 8] = payload[4 * b + i];
                    end
                end
                else
                begin
                    exp_ovf = 1'b1;
                end
            end
            exp_len  = row.len;
            exp_meta = row.meta;
            exp_done = 1'b1;
            armed_m  = 1'b0;
        end
    endtask

    task automatic check_results(input int idx);
        logic [31:0] rdata;
        int          cnt;
        reg_read(REG_STATUS, rdata);
        cnt = 0;
        while (exp_done && !rdata[0])
        begin
            if (cnt == TIMEOUT)
            begin
                $display("Timed out waiting for done after packet %0d", idx);
                fail_run();
            end
            reg_read(REG_STATUS, rdata);
            cnt++;
        end
        check_value($sformatf("row %0d status", idx), rdata, {30'b0, exp_ovf, exp_done});
        reg_read(REG_LENGTH, rdata);
        check_value($sformatf("row %0d length", idx), rdata, {16'b0, exp_len});
        reg_read(REG_META, rdata);
        check_value($sformatf("row %0d meta", idx), rdata, exp_meta);
        for (int w = 0; w < DEPTH; w++)
        begin
            reg_read(REG_DATA_BASE + REG_ADDR_WID'(w), rdata);
            check_value($sformatf("row %0d data word %0d", idx, w), rdata, ref_mem[w]);
        end
    endtask

    task automatic run_row(input int idx, input row_t row);
        for (int i = 0; i < row.len; i++)
            payload[i] = 8'($random(seed));
        if (row.arm_mode == ARM_BEFORE)
        begin
            reg_write(REG_CONTROL, {30'b0, 1'b1, row.en});
            @(negedge clk);
        end
        else
        begin
            reg_write(REG_CONTROL, {31'b0, row.en});
        end
        // First beat waits at the input while en is low
        if (!row.en)
        begin
            set_beat(0, row);
            for (int c = 0; c < row.idle; c++)
            begin
                check_value($sformatf("row %0d tready while disabled", idx), {31'b0, tready}, 0);
                @(negedge clk);
            end
            reg_write(REG_CONTROL, 32'h1);
        end
        send_packet(row);
        update_model(row);
        check_results(idx);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial
    begin
        logic [31:0] rdata;
        arst_n    = 1'b0;
        tvalid    = 1'b0;
        tdata     = '0;
        tkeep     = '0;
        tlast     = 1'b0;
        tid       = '0;
        tdest     = '0;
        tuser     = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (int w = 0; w < DEPTH; w++)
            ref_mem[w] = 'x;
        armed_m  = 1'b0;
        exp_done = 1'b0;
        exp_ovf  = 1'b0;
        exp_len  = '0;
        exp_meta = 'x;

        // Length, meta, arm mode, en, idle cycles
        rows[0] = '{16'd24,  32'h3C70A5F1, ARM_NONE,      1'b1, 8'd0};
        rows[1] = '{16'd13,  32'h81A12345, ARM_BEFORE,    1'b1, 8'd0};
        rows[2] = '{16'd64,  32'h0F5FFFFF, ARM_BEFORE,    1'b1, 8'd0};
        rows[3] = '{16'd40,  32'h55300001, ARM_IN_FLIGHT, 1'b1, 8'd0};
        rows[4] = '{16'd30,  32'hC6ED0C0D, ARM_NONE,      1'b1, 8'd0};
        rows[5] = '{16'd100, 32'h7E2BEEF0, ARM_BEFORE,    1'b1, 8'd0};
        rows[6] = '{16'd22,  32'h9A4F00A0, ARM_BEFORE,    1'b0, 8'd6};
        rows[7] = '{16'd7,   32'h12345678, ARM_BEFORE,    1'b1, 8'd0};

        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        check_value("tready after reset", {31'b0, tready}, 0);
        check_value("read valid after reset", {31'b0, reg_rvalid}, 0);
        reg_read(REG_MEM_SIZE, rdata);
        check_value("memory size", rdata, MEM_SIZE);
        reg_read(REG_META_WID, rdata);
        check_value("meta width", rdata, 32);
        reg_read(REG_STATUS, rdata);
        check_value("status after reset", rdata, 0);

        for (int r = 0; r < N_ROWS; r++)
            run_row(r, rows[r]);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
